// ==== source/uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clocks per bit on the serial line
`define UART_OVERSAMPLE 16

// Start edge to middle of the start bit
`define UART_HALF_BIT 8

// Widest data word the device carries
`define UART_MAX_DATA_BITS 9

// Bit timers in both directions are four bits wide,
// so the oversample count must stay at or below 16
// and the half-bit count must stay at or above 1

`endif

// ==== source/uart_frame_pkg.sv ====
`default_nettype none

package uart_frame_pkg;

    // Three-bit code for the data length
    typedef enum logic [2:0] {
        DATA_BITS_5 = 3'd0,
        DATA_BITS_6 = 3'd1,
        DATA_BITS_7 = 3'd2,
        DATA_BITS_8 = 3'd3,
        DATA_BITS_9 = 3'd4
    } data_bits_t;

    typedef struct packed {
        data_bits_t data_bits;
        logic       parity_en;
        logic       parity_even;  // 0 selects odd parity
        logic       two_stop;     // 0 gives one stop bit
    } frame_cfg_t;

    // Number of data bits for a length code
    function automatic logic [3:0] data_len(data_bits_t code);
        logic [3:0] len;
        case (code)
            DATA_BITS_5: len = 4'd5;
            DATA_BITS_6: len = 4'd6;
            DATA_BITS_7: len = 4'd7;
            DATA_BITS_9: len = 4'd9;
            default:     len = 4'd8;  // Includes the unused codes
        endcase
        return len;
    endfunction

endpackage

`default_nettype wire

// ==== source/uart_ctrl_pkg.sv ====
`default_nettype none

`include "uart_settings.svh"

package uart_ctrl_pkg;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    typedef logic [`UART_MAX_DATA_BITS-1:0] uart_word_t;

    typedef struct packed {
        uart_word_t data;  // LSB goes out first
    } tx_req_t;

    typedef struct packed {
        uart_word_t data;          // Bits above the frame length read 0
        logic       parity_error;
        logic       frame_error;   // Some stop bit sampled low
    } rx_word_t;

endpackage

`default_nettype wire

// ==== source/uart_tx.sv ====
`default_nettype none

`include "uart_settings.svh"

module uart_tx (
    input  logic                       uart_clk,
    input  logic                       reset,
    input  uart_frame_pkg::frame_cfg_t cfg,
    input  uart_ctrl_pkg::tx_req_t     tx_req,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    output logic                       line
);

    import uart_frame_pkg::*;
    import uart_ctrl_pkg::*;

    localparam logic [3:0] BIT_END = 4'(`UART_OVERSAMPLE - 1);

    tx_state_t  state;
    frame_cfg_t cfg_q;       // Format held for the whole frame
    uart_word_t shift_q;     // Current data bit sits in bit 0
    logic [3:0] bit_timer;
    logic [3:0] bit_idx;     // Data bit, later stop bit
    logic       parity_acc;
    logic       bit_done;
    logic       accept;

    assign accept   = tx_valid && tx_ready;
    assign bit_done = (bit_timer == BIT_END);
    assign tx_ready = (state == TX_IDLE);

    // ----------------------------------------
    // Frame sequencer
    // ----------------------------------------
    always_ff @(posedge uart_clk)
    begin
        if (reset)
        begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
        end
        else
        begin
            if (state == TX_IDLE || bit_done)
                bit_timer <= '0;
            else
                bit_timer <= bit_timer + 4'd1;

            case (state)
                TX_IDLE:
                    if (accept)
                        state <= TX_START;
                TX_START:
                    if (bit_done)
                    begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                TX_DATA:
                    if (bit_done)
                    begin
                        if (bit_idx == data_len(cfg_q.data_bits) - 4'd1)
                        begin
                            bit_idx <= '0;  // Reused to count stop bits
                            state   <= cfg_q.parity_en ? TX_PARITY : TX_STOP;
                        end
                        else
                            bit_idx <= bit_idx + 4'd1;
                    end
                TX_PARITY:
                    if (bit_done)
                        state <= TX_STOP;
                TX_STOP:
                    if (bit_done)
                    begin
                        if (bit_idx == {3'b000, cfg_q.two_stop})
                            state <= TX_IDLE;
                        else
                            bit_idx <= bit_idx + 4'd1;
                    end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // Word and format are captured at the handshake
    always_ff @(posedge uart_clk)
    begin
        if (accept)
        begin
            cfg_q      <= cfg;
            shift_q    <= tx_req.data;
            parity_acc <= 1'b0;
        end
        else if (state == TX_DATA && bit_done)
        begin
            shift_q    <= shift_q >> 1;
            parity_acc <= parity_acc ^ shift_q[0];
        end
    end

    always_comb
    begin
        case (state)
            TX_START:  line = 1'b0;
            TX_DATA:   line = shift_q[0];
            TX_PARITY: line = parity_acc ^ ~cfg_q.parity_even;  // Odd parity inverts
            default:   line = 1'b1;  // Idle and stop bits
        endcase
    end

    // Line only moves at a bit boundary or at the handshake
    a_bit_hold: assert property (@(posedge uart_clk) disable iff (reset)
        !(bit_done || accept) |=> $stable(line));

    // Ready returns only after a full-length stop bit
    a_ready_after_stop: assert property (@(posedge uart_clk) disable iff (reset)
        $rose(tx_ready) |-> $past(state, `UART_OVERSAMPLE) == TX_STOP);

endmodule

`default_nettype wire

// ==== source/uart_rx.sv ====
`default_nettype none

`include "uart_settings.svh"

module uart_rx (
    input  logic                       uart_clk,
    input  logic                       reset,
    input  uart_frame_pkg::frame_cfg_t cfg,
    input  logic                       line,
    output uart_ctrl_pkg::rx_word_t    rx_word,
    output logic                       rx_valid
);

    import uart_frame_pkg::*;
    import uart_ctrl_pkg::*;

    localparam logic [3:0] HALF_LOAD = 4'(`UART_HALF_BIT - 1);
    localparam logic [3:0] FULL_LOAD = 4'(`UART_OVERSAMPLE - 1);

    rx_state_t  state;
    logic       line_meta;
    logic       line_sync;
    logic [3:0] sample_timer;   // Counts down to the next sample point
    logic [3:0] bit_idx;
    uart_word_t data_q;
    logic       parity_acc;
    logic       parity_err;
    logic       frame_err;
    logic       sample;
    logic       last_data;
    logic       expected_parity;

    assign sample          = (sample_timer == '0);
    assign last_data       = (bit_idx == data_len(cfg.data_bits) - 4'd1);
    assign expected_parity = parity_acc ^ ~cfg.parity_even;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge uart_clk)
    begin
        if (reset)
        begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
        end
        else
        begin
            line_meta <= line;
            line_sync <= line_meta;
        end
    end

    // ----------------------------------------
    // Receive FSM
    // ----------------------------------------
    always_ff @(posedge uart_clk)
    begin
        if (reset)
        begin
            state        <= RX_IDLE;
            sample_timer <= '0;
            bit_idx      <= '0;
            rx_valid     <= 1'b0;
            rx_word      <= '0;
        end
        else
        begin
            rx_valid <= 1'b0;
            if (!sample)
                sample_timer <= sample_timer - 4'd1;

            case (state)
                RX_IDLE:
                    if (!line_sync)  // Falling edge of a start bit
                    begin
                        state        <= RX_START;
                        sample_timer <= HALF_LOAD;
                    end
                RX_START:
                    if (sample)
                    begin
                        if (line_sync)
                            state <= RX_IDLE;  // Glitch, not a start bit
                        else
                        begin
                            state        <= RX_DATA;
                            sample_timer <= FULL_LOAD;
                            bit_idx      <= '0;
                        end
                    end
                RX_DATA:
                    if (sample)
                    begin
                        sample_timer <= FULL_LOAD;
                        if (last_data)
                        begin
                            bit_idx <= '0;
                            state   <= cfg.parity_en ? RX_PARITY : RX_STOP;
                        end
                        else
                            bit_idx <= bit_idx + 4'd1;
                    end
                RX_PARITY:
                    if (sample)
                    begin
                        sample_timer <= FULL_LOAD;
                        state        <= RX_STOP;
                    end
                RX_STOP:
                    if (sample)
                    begin
                        sample_timer <= FULL_LOAD;
                        if (bit_idx == {3'b000, cfg.two_stop})
                        begin
                            state                <= RX_IDLE;
                            rx_valid             <= 1'b1;
                            rx_word.data         <= data_q;
                            rx_word.parity_error <= parity_err;
                            rx_word.frame_error  <= frame_err | ~line_sync;
                        end
                        else
                            bit_idx <= bit_idx + 4'd1;
                    end
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

    // Word assembly and checks, cleared between frames
    always_ff @(posedge uart_clk)
    begin
        if (state == RX_IDLE)
        begin
            data_q     <= '0;
            parity_acc <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
        end
        else if (sample)
        begin
            case (state)
                RX_DATA:
                begin
                    data_q[bit_idx] <= line_sync;
                    parity_acc      <= parity_acc ^ line_sync;
                end
                RX_PARITY: parity_err <= (line_sync != expected_parity);
                RX_STOP:   frame_err  <= frame_err | ~line_sync;
                default:   ;
            endcase
        end
    end

    a_valid_single: assert property (@(posedge uart_clk) disable iff (reset)
        rx_valid |=> !rx_valid);

    // A word is only delivered after a full-length stop bit
    a_valid_after_stop: assert property (@(posedge uart_clk) disable iff (reset)
        rx_valid |-> $past(state) == RX_STOP
                     && $past(state, `UART_OVERSAMPLE) == RX_STOP);

endmodule

`default_nettype wire

// ==== source/uart_device.sv ====
`default_nettype none

module uart_device (
    input  logic                       uart_clk,
    input  logic                       reset,
    input  uart_frame_pkg::frame_cfg_t cfg,      // Shared by both directions
    input  uart_ctrl_pkg::tx_req_t     tx_req,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    output uart_ctrl_pkg::rx_word_t    rx_word,
    output logic                       rx_valid,
    output logic                       uart_tx,
    input  logic                       uart_rx
);

    uart_tx u_tx (
        .uart_clk (uart_clk),
        .reset    (reset),
        .cfg      (cfg),
        .tx_req   (tx_req),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .line     (uart_tx)
    );

    uart_rx u_rx (
        .uart_clk (uart_clk),
        .reset    (reset),
        .cfg      (cfg),
        .line     (uart_rx),  // Asynchronous pin
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

endmodule

`default_nettype wire

// ==== dv/uart_device_tb.sv ====
`default_nettype none

`include "uart_settings.svh"

module uart_device_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_frame_pkg::*;
    import uart_ctrl_pkg::*;

    localparam int BIT_CLKS = `UART_OVERSAMPLE;
    localparam int TIMEOUT  = 2 * 16 * BIT_CLKS;  // Two of the longest frames

    logic       uart_clk;
    logic       reset;
    frame_cfg_t cfg;
    tx_req_t    tx_req;
    logic       tx_valid;
    logic       tx_ready;
    rx_word_t   rx_word;
    logic       rx_valid;
    logic       uart_tx;
    logic       uart_rx;
    logic       loop_sel;   // 1 routes the transmitter into the receiver
    logic       drive_bit;
    rx_word_t   last_word;
    int         rx_count = 0;
    int         checks = 0;
    int         errors = 0;

    assign uart_rx = loop_sel ? uart_tx : drive_bit;

    uart_device u_uart_device (
        .uart_clk (uart_clk),
        .reset    (reset),
        .cfg      (cfg),
        .tx_req   (tx_req),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .uart_tx  (uart_tx),
        .uart_rx  (uart_rx)
    );

    initial
    begin
        uart_clk = 1'b0;
        forever #10 uart_clk = ~uart_clk;
    end

    // Captures each received word on its valid pulse
    always @(posedge uart_clk)
    begin
        if (rx_valid)
        begin
            last_word = rx_word;
            rx_count  = rx_count + 1;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic step(input int n);
        repeat (n) @(posedge uart_clk);
        #2;  // Drive and sample just after the edge
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors)
            $display("[%s] ok", name);
        else
            $display("[%s] %0d errors", name, errors - start_errors);
    endtask

    function automatic frame_cfg_t make_cfg(input int n, input int par, input logic two);
        frame_cfg_t c;
        c.data_bits   = data_bits_t'(3'(n - 5));
        c.parity_en   = (par != 0);  // 1 even, 2 odd
        c.parity_even = (par == 1);
        c.two_stop    = two;
        return c;
    endfunction

    function automatic int frame_len(input int n, input frame_cfg_t c);
        return 1 + n + int'(c.parity_en) + (c.two_stop ? 2 : 1);
    endfunction

    // Line levels of a frame, bit 0 first, unused positions high
    function automatic logic [15:0] expected_frame(input int n, input frame_cfg_t c,
                                                   input logic [8:0] d);
        logic [15:0] bits;
        logic        par;
        bits    = '1;
        bits[0] = 1'b0;
        par     = 1'b0;
        for (int i = 0; i < n; i++)
        begin
            bits[1 + i] = d[i];
            par         = par ^ d[i];
        end
        if (c.parity_en)
            bits[1 + n] = c.parity_even ? par : ~par;
        return bits;
    endfunction

    function automatic logic [8:0] mask_data(input int n, input logic [8:0] d);
        return d & ((9'd1 << n) - 9'd1);
    endfunction

    task automatic wait_word(input int start_count);
        int guard;
        guard = 0;
        while (rx_count == start_count && guard < TIMEOUT)
        begin
            guard++;
            step(1);
        end
        if (rx_count == start_count)
        begin
            errors++;
            $display("Timeout at %0t, the receiver delivered no word", $time);
        end
    endtask

    task automatic check_word(input logic [8:0] data, input logic par_err,
                              input logic frm_err);
        check_value("rx_word.data", 16'(data), 16'(last_word.data));
        check_value("rx_word.parity_error", 16'(par_err), 16'(last_word.parity_error));
        check_value("rx_word.frame_error", 16'(frm_err), 16'(last_word.frame_error));
    endtask

    task automatic drive_frame(input logic [15:0] bits, input int len);
        for (int i = 0; i < len; i++)
        begin
            drive_bit = bits[i];
            step(BIT_CLKS);
        end
        drive_bit = 1'b1;
    endtask

    // Sends one word in loopback, watches the line and the busy time
    task automatic send_and_check(input int n, input logic [8:0] data);
        logic [15:0] got_bits;
        int          len;
        int          busy;
        int          guard;
        int          start_count;
        got_bits    = '1;
        len         = frame_len(n, cfg);
        start_count = rx_count;
        guard       = 0;
        while (!tx_ready && guard < TIMEOUT)
        begin
            guard++;
            step(1);
        end
        if (!tx_ready)
        begin
            errors++;
            $display("Timeout at %0t, the transmitter never became ready", $time);
            return;
        end
        tx_req.data = data;
        tx_valid    = 1'b1;
        step(1);  // Accepted on this edge
        tx_valid    = 1'b0;
        busy        = 0;
        while (!tx_ready && busy < 16 * BIT_CLKS)
        begin
            if (busy % BIT_CLKS == `UART_HALF_BIT)
                got_bits[busy / BIT_CLKS] = uart_tx;
            busy++;
            step(1);
        end
        check_value("uart_tx frame", expected_frame(n, cfg, data), got_bits);
        check_value("tx_ready low cycles", 16'(BIT_CLKS * len), 16'(busy));
        wait_word(start_count);
        check_word(mask_data(n, data), 1'b0, 1'b0);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset();
        int start_errors;
        int start_count;
        start_errors = errors;
        start_count  = rx_count;
        check_value("tx_ready", 16'd1, 16'(tx_ready));
        check_value("uart_tx", 16'd1, 16'(uart_tx));
        check_value("rx_word", 16'd0, 16'(rx_word));
        step(200);
        check_value("rx_valid pulses", 16'(start_count), 16'(rx_count));
        report_test("reset", start_errors);
    endtask

    task automatic test_loopback();
        int start_errors;
        start_errors = errors;
        loop_sel     = 1'b1;
        cfg          = make_cfg(8, 0, 1'b0);
        for (int i = 0; i < 20; i++)
            send_and_check(8, 9'($urandom));
        report_test("loopback", start_errors);
    endtask

    task automatic test_formats();
        int start_errors;
        start_errors = errors;
        loop_sel     = 1'b1;
        for (int n = 5; n <= 9; n++)
            for (int par = 0; par < 3; par++)
                for (int s = 0; s < 2; s++)
                begin
                    cfg = make_cfg(n, par, s[0]);  // Receiver idle between frames
                    send_and_check(n, 9'($urandom));
                end
        report_test("formats", start_errors);
    endtask

    task automatic test_parity();
        int          start_errors;
        int          start_count;
        logic [8:0]  data;
        logic [15:0] bits;
        start_errors = errors;
        loop_sel     = 1'b0;
        for (int par = 1; par < 3; par++)
            for (int bad = 0; bad < 2; bad++)
            begin
                cfg  = make_cfg(8, par, 1'b0);
                data = 9'($urandom);
                bits = expected_frame(8, cfg, data);
                if (bad != 0)
                    bits[9] = ~bits[9];  // Flip the parity bit
                start_count = rx_count;
                drive_frame(bits, 11);
                wait_word(start_count);
                check_word(mask_data(8, data), bad[0], 1'b0);
                step(BIT_CLKS);
            end
        report_test("parity", start_errors);
    endtask

    task automatic test_framing();
        int          start_errors;
        int          start_count;
        logic [8:0]  data;
        logic [15:0] bits;
        start_errors = errors;
        loop_sel     = 1'b0;
        for (int s = 0; s < 2; s++)
        begin
            cfg  = make_cfg(8, 0, s[0]);
            data = 9'($urandom);
            bits = expected_frame(8, cfg, data);
            bits[9 + s] = 1'b0;  // Last stop bit low
            start_count = rx_count;
            drive_frame(bits, 10 + s);
            wait_word(start_count);
            check_word(mask_data(8, data), 1'b0, 1'b1);
            step(2 * BIT_CLKS);  // Receiver rejects the trailing low level
        end
        report_test("framing", start_errors);
    endtask

    task automatic test_glitch();
        int         start_errors;
        int         start_count;
        logic [8:0] data;
        start_errors = errors;
        loop_sel     = 1'b0;
        cfg          = make_cfg(8, 0, 1'b0);
        start_count  = rx_count;
        drive_bit    = 1'b0;
        step(4);
        drive_bit    = 1'b1;
        step(2 * 10 * BIT_CLKS);
        check_value("rx_valid pulses", 16'(start_count), 16'(rx_count));
        data = 9'($urandom);
        drive_frame(expected_frame(8, cfg, data), 10);
        wait_word(start_count);
        check_word(mask_data(8, data), 1'b0, 1'b0);
        report_test("glitch", start_errors);
    endtask

    initial
    begin
        void'($urandom(6));
        reset     = 1'b1;
        cfg       = make_cfg(8, 0, 1'b0);
        tx_req    = '0;
        tx_valid  = 1'b0;
        loop_sel  = 1'b1;
        drive_bit = 1'b1;
        step(8);
        reset = 1'b0;
        step(2);

        test_reset();
        test_loopback();
        test_formats();
        test_parity();
        test_framing();
        test_glitch();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
source/uart_frame_pkg.sv
source/uart_ctrl_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_device.sv
dv/uart_device_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = uart_device_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass or fail comes from the log, not from the exit status of the run
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
